//--- dv/trap_unit_checker.sv
// ################################################
// cycle model of the trap unit csrs and sequence timing
// samples dut ports on each rising edge, counts checks and errors
// ################################################

`timescale 1ns/100ps

module trap_unit_checker #(
    parameter logic [trap_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  trap_pkg::trap_req_t             trap_req_i,
    input  logic                            div_busy_i,
    input  trap_pkg::csr_wr_t               sw_wr_i,
    input  logic [trap_pkg::CSR_ADDR_W-1:0] raddr_i,
    input  logic [trap_pkg::XLEN-1:0]       rdata_i,
    input  logic                            hold_i,
    input  logic                            redirect_i,
    input  logic [trap_pkg::XLEN-1:0]       redirect_addr_i,
    output int                              err_cnt_o,
    output int                              chk_cnt_o
);
    import trap_pkg::*;

    localparam int ST_IDLE    = 0;
    localparam int ST_MEPC    = 1;
    localparam int ST_MSTATUS = 2;
    localparam int ST_MCAUSE  = 3;
    localparam int ST_MRET    = 4;

    int              errs = 0;
    int              checks = 0;
    int              st;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] ret_addr;    // pending mepc value
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] mret_ms;     // mstatus after mret, fixed at take
    logic            redir;       // expected redirect in coming cycle
    logic [XLEN-1:0] redir_addr;
    logic            take_trap;
    logic            take_mret;

    assign err_cnt_o = errs;
    assign chk_cnt_o = checks;

    function automatic logic [XLEN-1:0] read_csr(input logic [CSR_ADDR_W-1:0] a);
        case (a)
            CSR_MTVEC:   return mtvec;
            CSR_MEPC:    return mepc;
            CSR_MCAUSE:  return mcause;
            CSR_MSTATUS: return mstatus;
            default:     return '0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] got);
        checks++;
        if (exp !== got) begin
            errs++;
            $display("ERROR %0t ns: %s expected %08h got %08h", $time, name, exp, got);
        end
    endtask

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            st      = ST_IDLE;
            mtvec   = MTVEC_RESET;
            mepc    = '0;
            mcause  = '0;
            mstatus = '0;
            redir   = 1'b0;
        end else begin
            take_trap = (st == ST_IDLE) && (trap_req_i.ecall || trap_req_i.ebreak)
                        && !div_busy_i;
            take_mret = (st == ST_IDLE) && trap_req_i.mret && !take_trap;
            compare("hold_o", {31'b0, (st != ST_IDLE) || take_trap || take_mret},
                    {31'b0, hold_i});
            compare("redirect_o", {31'b0, redir}, {31'b0, redirect_i});
            if (redir) compare("redirect_addr_o", redir_addr, redirect_addr_i);
            compare("csr_rdata_o", read_csr(raddr_i), rdata_i);
            redir = 1'b0;
            case (st)
                ST_IDLE: begin
                    if (take_trap) begin
                        ret_addr = trap_req_i.jump_flag ? trap_req_i.jump_addr - 32'd4
                                                        : trap_req_i.pc;
                        cause    = trap_req_i.ecall ? CAUSE_ECALL : CAUSE_BREAK;
                        st       = ST_MEPC;
                    end else if (take_mret) begin
                        mret_ms    = 32'h80 | (mstatus[7] ? 32'h8 : 32'h0);  // mie <= mpie
                        redir      = 1'b1;
                        redir_addr = mepc;        // value before any sw write
                        st         = ST_MRET;
                    end
                    if (sw_wr_i.we) begin         // sw port free only in idle
                        case (sw_wr_i.addr)
                            CSR_MTVEC:   mtvec   = sw_wr_i.data;
                            CSR_MEPC:    mepc    = sw_wr_i.data;
                            CSR_MCAUSE:  mcause  = sw_wr_i.data;
                            CSR_MSTATUS: mstatus = sw_wr_i.data & 32'h88;
                            default:     ;
                        endcase
                    end
                end
                ST_MEPC: begin
                    mepc = ret_addr;
                    st   = ST_MSTATUS;
                end
                ST_MSTATUS: begin
                    mstatus    = mstatus[3] ? 32'h80 : 32'h0;  // mpie <= mie, mie off
                    redir      = 1'b1;
                    redir_addr = mtvec;
                    st         = ST_MCAUSE;
                end
                ST_MCAUSE: begin
                    mcause = cause;
                    st     = ST_IDLE;
                end
                default: begin
                    mstatus = mret_ms;
                    st      = ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- dv/trap_unit_sva.sv
// ################################################
// concurrent checks on the trap sequencer, bound into trap_ctrl
// covers redirect length, write gating and state encoding
// ################################################

`timescale 1ns/100ps

module trap_unit_sva (
    input logic       clk,
    input logic       arst_n_i,
    input logic       hold_i,
    input logic       wr_we_i,
    input logic       redirect_i,
    input logic [4:0] state_i
);

    // redirect is a single cycle strobe
    redirect_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_i |=> !redirect_i)
        else $error("redirect_o high for more than one cycle");

    // csr writes from the sequencer only inside a stall window
    write_in_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        wr_we_i |-> (hold_i || $past(hold_i)))
        else $error("trap csr write outside the hold window");

    state_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot(state_i))
        else $error("sequencer state not one-hot");

endmodule

bind trap_ctrl trap_unit_sva sva0 (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .hold_i     (hold_o),
    .wr_we_i    (trap_wr_o.we),
    .redirect_i (redirect_o),
    .state_i    (state_q)
);

//--- dv/trap_unit_tb.sv
// ################################################
// testbench for the trap unit, seeded random requests and csr traffic
// drives on the falling edge, trap_unit_checker does the comparing
// ################################################

`timescale 1ns/100ps

module trap_unit_tb;
    import trap_pkg::*;

    localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100;
    localparam int N_TESTS = 6;
    localparam int N_TXN   = 40;    // transactions per test
    localparam int TXN_CYC = 10;    // cycle budget per transaction

    logic                  clk;
    logic                  arst_n;
    trap_req_t             trap_req;
    logic                  div_busy;
    csr_wr_t               sw_wr;
    logic [CSR_ADDR_W-1:0] raddr;
    logic [XLEN-1:0]       rdata;
    logic                  hold;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_addr;
    int                    errs;
    int                    checks;
    int                    tb_fails = 0;   // stuck hold and similar
    int                    mark;
    integer                seed = 48764;

    trap_unit_top #(.MTVEC_RESET(MTVEC_RESET)) dut0 (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .trap_req_i      (trap_req),
        .div_busy_i      (div_busy),
        .sw_wr_i         (sw_wr),
        .csr_raddr_i     (raddr),
        .csr_rdata_o     (rdata),
        .hold_o          (hold),
        .redirect_o      (redirect),
        .redirect_addr_o (redirect_addr)
    );

    trap_unit_checker #(.MTVEC_RESET(MTVEC_RESET)) chk0 (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .trap_req_i      (trap_req),
        .div_busy_i      (div_busy),
        .sw_wr_i         (sw_wr),
        .raddr_i         (raddr),
        .rdata_i         (rdata),
        .hold_i          (hold),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .err_cnt_o       (errs),
        .chk_cnt_o       (checks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 0..3 hit the four csrs, mepc and mcause weighted up, rest unmapped
    function automatic logic [CSR_ADDR_W-1:0] pick_addr(input logic [2:0] sel);
        logic [31:0] r;
        r = $random(seed);
        case (sel)
            3'd0:       return CSR_MSTATUS;
            3'd1:       return CSR_MTVEC;
            3'd2, 3'd5: return CSR_MEPC;
            3'd3, 3'd6: return CSR_MCAUSE;
            default:    return r[11:0];   // mostly unknown addresses
        endcase
    endfunction

    task automatic drive_sw(input logic en, input logic always_we);
        logic [31:0] r;
        r = $random(seed);
        sw_wr.we   = en & (always_we | r[0]);
        sw_wr.addr = pick_addr(r[3:1]);
        sw_wr.data = $random(seed);
        raddr      = pick_addr(r[6:4]);
    endtask

    // one request on a falling edge, then wait for the sequence to drain
    task automatic issue(input logic ec, input logic eb, input logic mr,
                         input logic busy, input logic clash);
        logic [31:0] r;
        int          n;
        @(negedge clk);
        r                  = $random(seed);
        trap_req.ecall     = ec;
        trap_req.ebreak    = eb;
        trap_req.mret      = mr;
        trap_req.pc        = $random(seed);
        trap_req.jump_flag = r[0];
        trap_req.jump_addr = $random(seed);
        div_busy           = busy;
        drive_sw(1'b1, 1'b0);
        n = 0;
        @(negedge clk);
        trap_req = '0;
        div_busy = r[1];               // ignored once the sequence runs
        drive_sw(1'b1, clash);
        while (hold && n < TXN_CYC) begin
            @(negedge clk);
            drive_sw(1'b1, clash);
            n++;
        end
        if (hold) begin
            tb_fails++;
            $display("hold_o did not return low after a request at %0t ns", $time);
        end
    endtask

    task automatic end_test(input string name);
        $display("%-22s done, %0d errors", name, errs + tb_fails - mark);
        mark = errs + tb_fails;
    endtask

    // watchdog sized from the test budget
    initial begin
        #(N_TESTS * N_TXN * TXN_CYC * 20);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        arst_n   = 1'b0;
        trap_req = '0;
        div_busy = 1'b0;
        sw_wr    = '0;
        raddr    = '0;
        mark     = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < 5; i++) begin  // reset readback
            @(negedge clk);
            raddr = pick_addr(3'(i));
        end
        end_test("reset values");
        for (int i = 0; i < N_TXN; i++) begin
            r = $random(seed);
            issue(r[0], r[1] | ~r[0], 1'b0, 1'b0, 1'b0);
        end
        end_test("ecall/ebreak");
        for (int i = 0; i < N_TXN; i++) begin
            r = $random(seed);
            issue(1'b0, 1'b0, 1'b1, r[0], 1'b0);
        end
        end_test("mret");
        for (int i = 0; i < N_TXN; i++) begin
            @(negedge clk);
            drive_sw(1'b1, 1'b0);
        end
        end_test("software csr access");
        for (int i = 0; i < N_TXN; i++) begin
            r = $random(seed);
            issue(r[0], r[1], r[2] & r[3], 1'b1, 1'b0);   // traps dropped, mret taken
        end
        end_test("divider busy");
        for (int i = 0; i < N_TXN; i++) begin
            r = $random(seed);
            issue(r[0], r[1], r[2], 1'b0, 1'b1);           // sw write every cycle
        end
        end_test("write collision");
        repeat (2) @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errs + tb_fails);
        if (errs + tb_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- hw/csr_file.sv
// ################################################
// machine csrs mtvec, mepc, mcause and mstatus
// software read/write port plus a trap write port that wins
// reads are combinational, unknown addresses read zero
// ################################################

`timescale 1ns/100ps

module csr_file #(
    parameter logic [trap_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  trap_pkg::csr_wr_t               trap_wr_i,  // from sequencer
    input  trap_pkg::csr_wr_t               sw_wr_i,    // csr instructions
    input  logic [trap_pkg::CSR_ADDR_W-1:0] raddr_i,
    output logic [trap_pkg::XLEN-1:0]       rdata_o,
    output trap_pkg::csr_view_t             view_o      // live values to sequencer
);
    import trap_pkg::*;

    csr_wr_t         wr;        // winning write
    csr_word_u       wdata_u;
    csr_word_u       ms_wdata;  // mstatus write with reserved bits cleared
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    csr_word_u       mstatus_q;

    // trap port has priority, a colliding sw write is dropped
    assign wr = trap_wr_i.we ? trap_wr_i : sw_wr_i;

    assign wdata_u.raw = wr.data;

    // only mie and mpie implemented
    always_comb begin
        ms_wdata.raw     = '0;
        ms_wdata.ms.mie  = wdata_u.ms.mie;
        ms_wdata.ms.mpie = wdata_u.ms.mpie;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtvec_q       <= MTVEC_RESET;
            mepc_q        <= '0;
            mcause_q      <= '0;
            mstatus_q.raw <= '0;
        end else if (wr.we) begin
            case (wr.addr)
                CSR_MTVEC:   mtvec_q   <= wdata_u.raw;
                CSR_MEPC:    mepc_q    <= wdata_u.raw;   // full 32 bits kept
                CSR_MCAUSE:  mcause_q  <= wdata_u.raw;
                CSR_MSTATUS: mstatus_q <= ms_wdata;
                default:     ;                           // unmapped, ignored
            endcase
        end
    end

    // read mux
    always_comb begin
        case (raddr_i)
            CSR_MTVEC:   rdata_o = mtvec_q;
            CSR_MEPC:    rdata_o = mepc_q;
            CSR_MCAUSE:  rdata_o = mcause_q;
            CSR_MSTATUS: rdata_o = mstatus_q.raw;
            default:     rdata_o = '0;
        endcase
    end

    assign view_o.mtvec   = mtvec_q;
    assign view_o.mepc    = mepc_q;
    assign view_o.mstatus = mstatus_q.raw;

endmodule

//--- hw/trap_ctrl.sv
// ################################################
// trap sequencer for ecall, ebreak and mret
// stalls the pipe, writes mepc/mstatus/mcause in turn, then
// redirects fetch to mtvec, or to mepc on mret
// ################################################

`timescale 1ns/100ps

module trap_ctrl (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  trap_pkg::trap_req_t       trap_req_i,       // from ex
    input  logic                      div_busy_i,       // divider in flight
    input  trap_pkg::csr_view_t       csr_view_i,       // from csr file
    output logic                      hold_o,           // pipeline stall
    output trap_pkg::csr_wr_t         trap_wr_o,        // to csr file
    output logic                      redirect_o,       // fetch redirect strobe
    output logic [trap_pkg::XLEN-1:0] redirect_addr_o
);
    import trap_pkg::*;

    // one-hot sequencer states
    typedef enum logic [4:0] {
        S_IDLE    = 5'b00001,
        S_MEPC    = 5'b00010,
        S_MSTATUS = 5'b00100,
        S_MCAUSE  = 5'b01000,
        S_MRET    = 5'b10000
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic            idle;
    logic            take_trap;        // ecall/ebreak accepted this cycle
    logic            take_mret;
    logic [XLEN-1:0] ret_addr;         // value destined for mepc
    logic [XLEN-1:0] cause_q;
    csr_word_u       ms_cur;           // mstatus as it stands
    csr_word_u       ms_new;           // edited copy
    csr_wr_t         wr_d;
    logic            redirect_d;
    logic [XLEN-1:0] redirect_addr_d;

    // registered write port
    logic                  wr_we_q;
    logic [CSR_ADDR_W-1:0] wr_addr_q;
    logic [XLEN-1:0]       wr_data_q;

    assign idle = (state_q == S_IDLE);

    // sync traps wait for the divider, the pipe retries on its own
    assign take_trap = idle & (trap_req_i.ecall | trap_req_i.ebreak) & ~div_busy_i;
    // mret never blocked by the divider, a trap wins a tie
    assign take_mret = idle & trap_req_i.mret & ~take_trap;

    // stall from the request cycle until back in idle
    assign hold_o = ~idle | take_trap | take_mret;

    // pending jump means the trapping insn is the one before the target
    assign ret_addr = trap_req_i.jump_flag ? (trap_req_i.jump_addr - 32'd4)
                                           : trap_req_i.pc;

    assign ms_cur.raw = csr_view_i.mstatus;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (take_trap) begin
                    state_d = S_MEPC;
                end else if (take_mret) begin
                    state_d = S_MRET;
                end
            end
            S_MEPC:    state_d = S_MSTATUS;
            S_MSTATUS: state_d = S_MCAUSE;
            S_MCAUSE:  state_d = S_IDLE;    // trap done
            S_MRET:    state_d = S_IDLE;
            default:   state_d = S_IDLE;    // illegal encoding, recover
        endcase
    end

    // csr write and redirect for the state being entered
    // registered, so each lands during that state and commits at its end
    always_comb begin
        ms_new          = ms_cur;
        wr_d.we         = 1'b1;
        wr_d.addr       = '0;
        wr_d.data       = '0;
        redirect_d      = 1'b0;
        redirect_addr_d = csr_view_i.mtvec;
        case (state_d)
            S_MEPC: begin
                wr_d.addr = CSR_MEPC;
                wr_d.data = ret_addr;              // straight from the request
            end
            S_MSTATUS: begin
                ms_new.ms.mpie = ms_cur.ms.mie;    // stack mie
                ms_new.ms.mie  = 1'b0;             // handler runs masked
                wr_d.addr      = CSR_MSTATUS;
                wr_d.data      = ms_new.raw;
            end
            S_MCAUSE: begin
                wr_d.addr  = CSR_MCAUSE;
                wr_d.data  = cause_q;
                redirect_d = 1'b1;                 // jump to handler
            end
            S_MRET: begin
                ms_new.ms.mie   = ms_cur.ms.mpie;  // unstack
                ms_new.ms.mpie  = 1'b1;
                wr_d.addr       = CSR_MSTATUS;
                wr_d.data       = ms_new.raw;
                redirect_d      = 1'b1;
                redirect_addr_d = csr_view_i.mepc; // back to trapped insn
            end
            default: begin
                wr_d.we = 1'b0;                    // idle, no write
            end
        endcase
    end

    // control state
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= S_IDLE;
            wr_we_q    <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            wr_we_q    <= wr_d.we;
            redirect_o <= redirect_d;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        wr_addr_q <= wr_d.addr;
        wr_data_q <= wr_d.data;
        if (take_trap) begin
            // ecall beats ebreak
            cause_q <= trap_req_i.ecall ? CAUSE_ECALL : CAUSE_BREAK;
        end
        if (redirect_d) begin
            redirect_addr_o <= redirect_addr_d;
        end
    end

    assign trap_wr_o.we   = wr_we_q;
    assign trap_wr_o.addr = wr_addr_q;
    assign trap_wr_o.data = wr_data_q;

endmodule

//--- hw/trap_pkg.sv
// ################################################
// shared types and constants for the machine-mode trap unit
// csr addresses, mcause codes, request and write structs
// import into module bodies, use scoped names in port lists
// ################################################

package trap_pkg;

    // datapath and csr address widths
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // standard machine csr addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

    // synchronous exception codes
    localparam logic [XLEN-1:0] CAUSE_ECALL = 32'd11;  // ecall from m-mode
    localparam logic [XLEN-1:0] CAUSE_BREAK = 32'd3;   // breakpoint

    // execute stage report, one cycle strobes
    typedef struct packed {
        logic            ecall;
        logic            ebreak;
        logic            mret;
        logic [XLEN-1:0] pc;         // address of the trapping insn
        logic            jump_flag;  // jump pending in ex
        logic [XLEN-1:0] jump_addr;
    } trap_req_t;

    // one csr write, used by both write ports
    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csr_wr_t;

    // live csr values the sequencer reads
    typedef struct packed {
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mstatus;
    } csr_view_t;

    // mstatus layout, only mie and mpie implemented
    typedef struct packed {
        logic [23:0] rsv_hi;
        logic        mpie;     // bit 7
        logic [2:0]  rsv_mid;
        logic        mie;      // bit 3
        logic [2:0]  rsv_lo;
    } mstatus_t;

    // one csr word, raw for mepc/mtvec/mcause or as mstatus fields
    typedef union packed {
        logic [XLEN-1:0] raw;
        mstatus_t        ms;
    } csr_word_u;

endpackage

//--- hw/trap_unit_top.sv
// ################################################
// trap unit top, sequencer plus machine csr file
// MTVEC_RESET sets the handler address after reset
// ################################################

`timescale 1ns/100ps

module trap_unit_top #(
    parameter logic [trap_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  trap_pkg::trap_req_t             trap_req_i,
    input  logic                            div_busy_i,
    input  trap_pkg::csr_wr_t               sw_wr_i,
    input  logic [trap_pkg::CSR_ADDR_W-1:0] csr_raddr_i,
    output logic [trap_pkg::XLEN-1:0]       csr_rdata_o,
    output logic                            hold_o,
    output logic                            redirect_o,
    output logic [trap_pkg::XLEN-1:0]       redirect_addr_o
);
    import trap_pkg::*;

    csr_wr_t   trap_wr;   // sequencer to csr file
    csr_view_t csr_view;  // csr file back to sequencer

    trap_ctrl u_trap_ctrl (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .trap_req_i      (trap_req_i),
        .div_busy_i      (div_busy_i),
        .csr_view_i      (csr_view),
        .hold_o          (hold_o),
        .trap_wr_o       (trap_wr),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o)
    );

    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr_file (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .trap_wr_i (trap_wr),
        .sw_wr_i   (sw_wr_i),
        .raddr_i   (csr_raddr_i),
        .rdata_o   (csr_rdata_o),
        .view_o    (csr_view)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the trap unit testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module trap_unit_tb \
    -f trap_unit_top.f -o sim_trap_unit > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_trap_unit > sim.log 2>&1
cat sim.log

grep -qx "Test completed successfully" sim.log \
    && { echo "simulation PASSED"; exit 0; } \
    || { echo "simulation FAILED"; exit 1; }

//--- trap_unit_top.f
hw/trap_pkg.sv
hw/trap_ctrl.sv
hw/csr_file.sv
hw/trap_unit_top.sv
dv/trap_unit_sva.sv
dv/trap_unit_checker.sv
dv/trap_unit_tb.sv
